// ==== source/ingress_cfg.svh ====
`ifndef INGRESS_CFG_SVH
`define INGRESS_CFG_SVH

// Stream and register width
`define INGRESS_DW 32

// Header dword 0 fields
`define TLP_FMT_RANGE 30:29
`define TLP_TYPE_RANGE 28:24
`define TLP_LEN_RANGE 9:0
`define TLP_TYPE_MEM 5'b00000
`define TLP_TYPE_CPL 5'b01010

// Completion header dword 2
`define CPL_LOWER_ADDR_RANGE 6:0

// Register offsets in dwords from the control base
`define REG_STATUS_ADDR 0
`define REG_WRITE_A_ADDR 1
`define REG_WRITE_B_ADDR 2
`define REG_READ_A_ADDR 3
`define REG_READ_B_ADDR 4
`define REG_BUFFER_SIZE 5
`define REG_DEV_ADDR 6

// Command region starts here
`define CMD_OFFSET 16
`define CMD_RESET 16
`define CMD_PERIPH_WRITE 17
`define CMD_PERIPH_READ 18
`define CMD_MEM_WRITE 19
`define CMD_MEM_READ 20
`define CMD_PING 21

// Host buffer address width
`define BUF_AW 12

`endif

// ==== source/ingress_pkg.sv ====
`default_nettype none

`include "ingress_cfg.svh"

package ingress_pkg;

  typedef enum logic [2:0] {
    IDLE,
    BAR_READ,
    BAR_RELEASE,
    HEADER,
    REG_WRITE,
    CPL_DATA,
    FLUSH
  } ingress_state_e;

  typedef enum logic [1:0] {
    KIND_MRD,
    KIND_MWR,
    KIND_CPLD,
    KIND_OTHER
  } tlp_kind_e;

  typedef enum logic [1:0] {
    SEL_CONTROL = 2'd0,
    SEL_PERIPH  = 2'd1,
    SEL_MEM     = 2'd2
  } device_sel_e;

  // Opcodes match the command offsets
  typedef enum logic [4:0] {
    OP_RESET        = `CMD_RESET,
    OP_PERIPH_WRITE = `CMD_PERIPH_WRITE,
    OP_PERIPH_READ  = `CMD_PERIPH_READ,
    OP_MEM_WRITE    = `CMD_MEM_WRITE,
    OP_MEM_READ     = `CMD_MEM_READ,
    OP_PING         = `CMD_PING
  } command_e;

endpackage

`default_nettype wire

// ==== source/ingress_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module ingress_fsm (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_valid,
  input  wire                     i_last,
  input  wire [6:0]               i_bar_hit,
  input  wire                     i_cfg_ack,
  input  wire [9:0]               i_count,
  input  wire [2:0]               i_hdr_size,
  input  var ingress_pkg::tlp_kind_e i_kind,
  input  wire [9:0]               i_len,
  input  wire                     i_cmd_reset,
  output logic                    o_ready,
  output logic                    o_cfg_req,
  output logic                    o_cnt_clear,
  output logic                    o_cnt_step,
  output logic                    o_hdr_capture,
  output logic                    o_reg_we,
  output logic                    o_buf_we_req
);

  ingress_pkg::ingress_state_e state;
  ingress_pkg::ingress_state_e state_next;
  logic cfg_done;
  logic accept;
  logic hdr_done;
  logic data_done;

  assign o_ready = (state == ingress_pkg::HEADER) || (state == ingress_pkg::REG_WRITE) ||
                   (state == ingress_pkg::CPL_DATA) || (state == ingress_pkg::FLUSH);
  assign accept = i_valid && o_ready;

  // Header size is only meaningful once dword 0 is stored
  assign hdr_done  = (i_count != 10'd0) && ((i_count + 10'd1) == {7'd0, i_hdr_size});
  assign data_done = (i_count + 10'd1) == i_len;

  assign o_cfg_req     = (state == ingress_pkg::BAR_READ);
  assign o_cnt_step    = accept;
  assign o_cnt_clear   = (state == ingress_pkg::IDLE) ||
                         ((state == ingress_pkg::HEADER) && accept && hdr_done);
  assign o_hdr_capture = accept && (state == ingress_pkg::HEADER);
  assign o_reg_we      = accept && (state == ingress_pkg::REG_WRITE);
  assign o_buf_we_req  = accept && (state == ingress_pkg::CPL_DATA);

  always_comb begin
    state_next = state;
    case (state)
      ingress_pkg::IDLE: begin
        if (i_valid) begin
          // First BAR hit after reset or a command reset fetches the BAR addresses
          if ((!cfg_done || i_cmd_reset) && (i_bar_hit != 7'd0)) begin
            state_next = ingress_pkg::BAR_READ;
          end else begin
            state_next = ingress_pkg::HEADER;
          end
        end
      end
      ingress_pkg::BAR_READ: begin
        if (i_cfg_ack) begin
          state_next = ingress_pkg::BAR_RELEASE;
        end
      end
      ingress_pkg::BAR_RELEASE: begin
        if (!i_cfg_ack) begin
          state_next = ingress_pkg::IDLE;
        end
      end
      ingress_pkg::HEADER: begin
        if (accept && i_last) begin
          state_next = ingress_pkg::IDLE;
        end else if (accept && hdr_done) begin
          case (i_kind)
            ingress_pkg::KIND_MWR:  state_next = ingress_pkg::REG_WRITE;
            ingress_pkg::KIND_CPLD: state_next = ingress_pkg::CPL_DATA;
            default:                state_next = ingress_pkg::FLUSH;
          endcase
        end
      end
      ingress_pkg::REG_WRITE: begin
        if (accept) begin
          state_next = i_last ? ingress_pkg::IDLE : ingress_pkg::FLUSH;
        end
      end
      ingress_pkg::CPL_DATA: begin
        if (accept && i_last) begin
          state_next = ingress_pkg::IDLE;
        end else if (accept && data_done) begin
          state_next = ingress_pkg::FLUSH;
        end
      end
      ingress_pkg::FLUSH: begin
        if (accept && i_last) begin
          state_next = ingress_pkg::IDLE;
        end
      end
      default: state_next = ingress_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ingress_pkg::IDLE;
      cfg_done <= 1'b0;
    end else begin
      state <= state_next;
      // Command reset re-arms the BAR read
      if (i_cmd_reset) begin
        cfg_done <= 1'b0;
      end else if ((state == ingress_pkg::BAR_RELEASE) && !i_cfg_ack) begin
        cfg_done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
  input  wire        clk,
  input  wire        rst,
  input  wire        i_clear,
  input  wire        i_step,
  output logic [9:0] o_count
);

  // Clear wins so the first data beat counts from zero
  always_ff @(posedge clk) begin
    if (rst) begin
      o_count <= 10'd0;
    end else if (i_clear) begin
      o_count <= 10'd0;
    end else if (i_step) begin
      o_count <= o_count + 10'd1;
    end
  end

endmodule

`default_nettype wire

// ==== source/tlp_header_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ingress_cfg.svh"

module tlp_header_decoder (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_capture,
  input  wire [1:0]                 i_index,
  input  wire [`INGRESS_DW-1:0]     i_data,
  output logic [2:0]                o_hdr_size,
  output ingress_pkg::tlp_kind_e    o_kind,
  output logic [9:0]                o_len,
  output logic [31:0]               o_addr,
  output logic [6:0]                o_lower_addr
);

  logic [`INGRESS_DW-1:0] hdr [0:3];
  logic [1:0] fmt;
  logic [4:0] tlp_type;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        hdr[i] <= '0;
      end
    end else if (i_capture) begin
      hdr[i_index] <= i_data;
    end
  end

  assign fmt      = hdr[0][`TLP_FMT_RANGE];
  assign tlp_type = hdr[0][`TLP_TYPE_RANGE];

  // Low format bit selects the 4 dword header
  assign o_hdr_size   = fmt[0] ? 3'd4 : 3'd3;
  assign o_len        = hdr[0][`TLP_LEN_RANGE];
  assign o_addr       = fmt[0] ? {hdr[3][31:2], 2'b00} : {hdr[2][31:2], 2'b00};
  assign o_lower_addr = hdr[2][`CPL_LOWER_ADDR_RANGE];

  always_comb begin
    if ((tlp_type == `TLP_TYPE_MEM) && !fmt[1]) begin
      o_kind = ingress_pkg::KIND_MRD;
    end else if ((tlp_type == `TLP_TYPE_MEM) && fmt[1]) begin
      o_kind = ingress_pkg::KIND_MWR;
    end else if ((tlp_type == `TLP_TYPE_CPL) && (fmt == 2'b10)) begin
      o_kind = ingress_pkg::KIND_CPLD;
    end else begin
      o_kind = ingress_pkg::KIND_OTHER;
    end
  end

endmodule

`default_nettype wire

// ==== source/control_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ingress_cfg.svh"

module control_reg_file (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_we,
  input  wire [31:0]                i_addr,
  input  wire [`INGRESS_DW-1:0]     i_data,
  input  wire [31:0]                i_control_addr_base,
  output logic [`INGRESS_DW-1:0]    o_status_addr,
  output logic [`INGRESS_DW-1:0]    o_write_a_addr,
  output logic [`INGRESS_DW-1:0]    o_write_b_addr,
  output logic [`INGRESS_DW-1:0]    o_read_a_addr,
  output logic [`INGRESS_DW-1:0]    o_read_b_addr,
  output logic [`INGRESS_DW-1:0]    o_buffer_size,
  output logic [`INGRESS_DW-1:0]    o_dev_addr,
  output logic [`INGRESS_DW-1:0]    o_ping_value,
  output logic                      o_reg_write_stb,
  output logic                      o_cmd_stb,
  output ingress_pkg::command_e     o_command,
  output ingress_pkg::device_sel_e  o_device_select,
  output logic [`INGRESS_DW-1:0]    o_cmd_data_count,
  output logic                      o_cmd_reset,
  output logic [7:0]                o_unknown_count
);

  logic [31:0] offset;
  logic        cmd_en;

  // Dword offset from the control BAR base
  assign offset = (i_addr - i_control_addr_base) >> 2;
  assign cmd_en = offset >= `CMD_OFFSET;

  always_ff @(posedge clk) begin
    o_reg_write_stb <= 1'b0;
    o_cmd_stb       <= 1'b0;
    o_cmd_reset     <= 1'b0;
    if (rst) begin
      o_status_addr    <= '0;
      o_write_a_addr   <= '0;
      o_write_b_addr   <= '0;
      o_read_a_addr    <= '0;
      o_read_b_addr    <= '0;
      o_buffer_size    <= '0;
      o_dev_addr       <= '0;
      o_ping_value     <= '0;
      o_command        <= ingress_pkg::OP_RESET;
      o_device_select  <= ingress_pkg::SEL_CONTROL;
      o_cmd_data_count <= '0;
      o_unknown_count  <= 8'd0;
    end else if (i_we && !cmd_en) begin
      o_reg_write_stb <= 1'b1;
      case (offset)
        `REG_STATUS_ADDR:  o_status_addr  <= i_data;
        `REG_WRITE_A_ADDR: o_write_a_addr <= i_data;
        `REG_WRITE_B_ADDR: o_write_b_addr <= i_data;
        `REG_READ_A_ADDR:  o_read_a_addr  <= i_data;
        `REG_READ_B_ADDR:  o_read_b_addr  <= i_data;
        `REG_BUFFER_SIZE:  o_buffer_size  <= i_data;
        `REG_DEV_ADDR:     o_dev_addr     <= i_data;
        default: begin
          o_reg_write_stb <= 1'b0;
          o_unknown_count <= o_unknown_count + 8'd1;
        end
      endcase
    end else if (i_we) begin
      o_cmd_stb        <= 1'b1;
      o_cmd_data_count <= i_data;
      case (offset)
        `CMD_RESET: begin
          o_command       <= ingress_pkg::OP_RESET;
          o_device_select <= ingress_pkg::SEL_CONTROL;
          o_cmd_reset     <= 1'b1;
        end
        `CMD_PERIPH_WRITE: begin
          o_command       <= ingress_pkg::OP_PERIPH_WRITE;
          o_device_select <= ingress_pkg::SEL_PERIPH;
        end
        `CMD_PERIPH_READ: begin
          o_command       <= ingress_pkg::OP_PERIPH_READ;
          o_device_select <= ingress_pkg::SEL_PERIPH;
        end
        `CMD_MEM_WRITE: begin
          o_command       <= ingress_pkg::OP_MEM_WRITE;
          o_device_select <= ingress_pkg::SEL_MEM;
        end
        `CMD_MEM_READ: begin
          o_command       <= ingress_pkg::OP_MEM_READ;
          o_device_select <= ingress_pkg::SEL_MEM;
        end
        `CMD_PING: begin
          o_command       <= ingress_pkg::OP_PING;
          o_device_select <= ingress_pkg::SEL_CONTROL;
          o_ping_value    <= i_data;
        end
        default: begin
          // Unknown command leaves the command registers alone
          o_cmd_stb        <= 1'b0;
          o_cmd_data_count <= o_cmd_data_count;
          o_unknown_count  <= o_unknown_count + 8'd1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/cpl_buffer_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ingress_cfg.svh"

module cpl_buffer_writer (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_we,
  input  wire [9:0]                 i_index,
  input  wire [`INGRESS_DW-1:0]     i_data,
  input  wire [6:0]                 i_lower_addr,
  input  wire [`BUF_AW-1:0]         i_buf_offset,
  output logic                      o_buf_we,
  output logic [`BUF_AW-1:0]        o_buf_addr,
  output logic [`INGRESS_DW-1:0]    o_buf_data
);

  logic [`BUF_AW-1:0] lower_dw;
  logic [`BUF_AW-1:0] index_ext;

  // Lower address is in bytes, buffer is in dwords
  assign lower_dw  = {{(`BUF_AW-5){1'b0}}, i_lower_addr[6:2]};
  assign index_ext = {{(`BUF_AW-10){1'b0}}, i_index};

  always_ff @(posedge clk) begin
    if (rst) begin
      o_buf_we <= 1'b0;
    end else begin
      o_buf_we <= i_we;
    end
  end

  always_ff @(posedge clk) begin
    if (i_we) begin
      o_buf_addr <= i_buf_offset + lower_dw + index_ext;
      o_buf_data <= i_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/pcie_ingress_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ingress_cfg.svh"

module pcie_ingress_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_valid,
  input  wire [`INGRESS_DW-1:0]     i_data,
  input  wire                       i_last,
  output logic                      o_ready,
  input  wire [6:0]                 i_bar_hit,
  input  wire [31:0]                i_control_addr_base,
  input  wire [`BUF_AW-1:0]         i_buf_offset,
  output logic                      o_cfg_req,
  input  wire                       i_cfg_ack,
  output logic [`INGRESS_DW-1:0]    o_status_addr,
  output logic [`INGRESS_DW-1:0]    o_write_a_addr,
  output logic [`INGRESS_DW-1:0]    o_write_b_addr,
  output logic [`INGRESS_DW-1:0]    o_read_a_addr,
  output logic [`INGRESS_DW-1:0]    o_read_b_addr,
  output logic [`INGRESS_DW-1:0]    o_buffer_size,
  output logic [`INGRESS_DW-1:0]    o_dev_addr,
  output logic [`INGRESS_DW-1:0]    o_ping_value,
  output logic                      o_reg_write_stb,
  output logic                      o_cmd_stb,
  output ingress_pkg::command_e     o_command,
  output ingress_pkg::device_sel_e  o_device_select,
  output logic [`INGRESS_DW-1:0]    o_cmd_data_count,
  output logic                      o_cmd_reset,
  output logic [7:0]                o_unknown_count,
  output logic                      o_buf_we,
  output logic [`BUF_AW-1:0]        o_buf_addr,
  output logic [`INGRESS_DW-1:0]    o_buf_data
);

  logic [9:0]             count;
  logic [2:0]             hdr_size;
  ingress_pkg::tlp_kind_e kind;
  logic [9:0]             len;
  logic [31:0]            addr;
  logic [6:0]             lower_addr;
  logic                   cnt_clear;
  logic                   cnt_step;
  logic                   hdr_capture;
  logic                   reg_we;
  logic                   buf_we_req;

  ingress_fsm u_fsm (
    .clk           (clk),
    .rst           (rst),
    .i_valid       (i_valid),
    .i_last        (i_last),
    .i_bar_hit     (i_bar_hit),
    .i_cfg_ack     (i_cfg_ack),
    .i_count       (count),
    .i_hdr_size    (hdr_size),
    .i_kind        (kind),
    .i_len         (len),
    .i_cmd_reset   (o_cmd_reset),
    .o_ready       (o_ready),
    .o_cfg_req     (o_cfg_req),
    .o_cnt_clear   (cnt_clear),
    .o_cnt_step    (cnt_step),
    .o_hdr_capture (hdr_capture),
    .o_reg_we      (reg_we),
    .o_buf_we_req  (buf_we_req)
  );

  beat_counter u_counter (
    .clk     (clk),
    .rst     (rst),
    .i_clear (cnt_clear),
    .i_step  (cnt_step),
    .o_count (count)
  );

  // Header dwords are indexed by the low count bits
  tlp_header_decoder u_decoder (
    .clk          (clk),
    .rst          (rst),
    .i_capture    (hdr_capture),
    .i_index      (count[1:0]),
    .i_data       (i_data),
    .o_hdr_size   (hdr_size),
    .o_kind       (kind),
    .o_len        (len),
    .o_addr       (addr),
    .o_lower_addr (lower_addr)
  );

  control_reg_file u_regs (
    .clk                 (clk),
    .rst                 (rst),
    .i_we                (reg_we),
    .i_addr              (addr),
    .i_data              (i_data),
    .i_control_addr_base (i_control_addr_base),
    .o_status_addr       (o_status_addr),
    .o_write_a_addr      (o_write_a_addr),
    .o_write_b_addr      (o_write_b_addr),
    .o_read_a_addr       (o_read_a_addr),
    .o_read_b_addr       (o_read_b_addr),
    .o_buffer_size       (o_buffer_size),
    .o_dev_addr          (o_dev_addr),
    .o_ping_value        (o_ping_value),
    .o_reg_write_stb     (o_reg_write_stb),
    .o_cmd_stb           (o_cmd_stb),
    .o_command           (o_command),
    .o_device_select     (o_device_select),
    .o_cmd_data_count    (o_cmd_data_count),
    .o_cmd_reset         (o_cmd_reset),
    .o_unknown_count     (o_unknown_count)
  );

  cpl_buffer_writer u_buf_writer (
    .clk          (clk),
    .rst          (rst),
    .i_we         (buf_we_req),
    .i_index      (count),
    .i_data       (i_data),
    .i_lower_addr (lower_addr),
    .i_buf_offset (i_buf_offset),
    .o_buf_we     (o_buf_we),
    .o_buf_addr   (o_buf_addr),
    .o_buf_data   (o_buf_data)
  );

endmodule

`default_nettype wire

// ==== bench/pcie_ingress_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcie_ingress_chk (
  input wire                    clk,
  input wire                    rst,
  input wire                    i_valid,
  input wire [31:0]             i_data,
  input wire                    i_last,
  input wire                    i_ready,
  input wire                    i_cfg_req,
  input wire                    i_cfg_ack,
  input wire                    i_buf_we,
  input var ingress_pkg::tlp_kind_e i_kind
);

  // A stalled beat keeps its data and last flag
  stall_hold: assert property (@(posedge clk) disable iff (rst)
    i_valid && !i_ready |=> i_valid && $stable(i_data) && $stable(i_last))
    else $error("stream beat changed while stalled");

  // Request stays up until the reader acknowledges
  req_hold: assert property (@(posedge clk) disable iff (rst)
    i_cfg_req && !i_cfg_ack |=> i_cfg_req)
    else $error("config request dropped before acknowledge");

  buf_in_cpl: assert property (@(posedge clk) disable iff (rst)
    i_buf_we |-> (i_kind == ingress_pkg::KIND_CPLD))
    else $error("buffer write outside a completion");

endmodule

bind pcie_ingress_top pcie_ingress_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .i_valid   (i_valid),
  .i_data    (i_data),
  .i_last    (i_last),
  .i_ready   (o_ready),
  .i_cfg_req (o_cfg_req),
  .i_cfg_ack (i_cfg_ack),
  .i_buf_we  (o_buf_we),
  .i_kind    (kind)
);

`default_nettype wire

// ==== bench/pcie_ingress_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ingress_cfg.svh"

module pcie_ingress_tb;

  localparam logic [31:0]         CTRL_BASE        = 32'h8000_0000;
  localparam logic [`BUF_AW-1:0]  BUF_OFFSET       = 12'h100;
  localparam int                  CYCLES_PER_ENTRY = 200;

  // Effect a packet must have on the outputs
  localparam logic [2:0] EFFECT_NONE    = 3'd0;
  localparam logic [2:0] EFFECT_REG     = 3'd1;
  localparam logic [2:0] EFFECT_CMD     = 3'd2;
  localparam logic [2:0] EFFECT_UNKNOWN = 3'd3;
  localparam logic [2:0] EFFECT_CPL     = 3'd4;

  typedef struct packed {
    logic [3:0][31:0] hdr;
    int               hdr_n;
    logic [3:0][31:0] dat;
    int               dat_n;
    logic [6:0]       bar_hit;
    logic             req;
    logic [2:0]       effect;
    int               idx;
    logic [31:0]      value;
    logic [1:0]       sel;
  } packet_t;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     i_valid;
  logic [31:0]              i_data;
  logic                     i_last;
  logic                     o_ready;
  logic [6:0]               i_bar_hit;
  logic [31:0]              i_control_addr_base;
  logic [`BUF_AW-1:0]       i_buf_offset;
  logic                     o_cfg_req;
  logic                     i_cfg_ack;
  logic [31:0]              o_status_addr;
  logic [31:0]              o_write_a_addr;
  logic [31:0]              o_write_b_addr;
  logic [31:0]              o_read_a_addr;
  logic [31:0]              o_read_b_addr;
  logic [31:0]              o_buffer_size;
  logic [31:0]              o_dev_addr;
  logic [31:0]              o_ping_value;
  logic                     o_reg_write_stb;
  logic                     o_cmd_stb;
  ingress_pkg::command_e    o_command;
  ingress_pkg::device_sel_e o_device_select;
  logic [31:0]              o_cmd_data_count;
  logic                     o_cmd_reset;
  logic [7:0]               o_unknown_count;
  logic                     o_buf_we;
  logic [`BUF_AW-1:0]       o_buf_addr;
  logic [31:0]              o_buf_data;

  packet_t            table_q[$];
  logic               table_ready = 1'b0;
  logic [6:0]         next_bar_hit;
  logic               arm_req;
  int                 error_count = 0;

  // Expected register state
  logic [31:0]        model_regs [0:6];
  logic [31:0]        model_ping;
  logic [4:0]         model_cmd;
  logic [1:0]         model_sel;
  logic [31:0]        model_count;
  logic [7:0]         model_unknown;

  // Seen by the output monitor during one packet
  int                 reg_stb_seen;
  int                 cmd_stb_seen;
  int                 reset_seen;
  int                 req_seen;
  logic               req_prev = 1'b0;
  logic [`BUF_AW-1:0] buf_addr_q[$];
  logic [31:0]        buf_data_q[$];

  pcie_ingress_top dut (.*);

  always #2 clk = ~clk;

  task automatic fail_run(input string msg);
    error_count++;
    $display("ERROR: %0t ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want)
      else fail_run($sformatf("%s is %08h, expected %08h", name, got, want));
  endtask

  task automatic push_packet(input packet_t p);
    p.bar_hit = next_bar_hit;
    p.req     = arm_req;
    arm_req   = 1'b0;
    table_q.push_back(p);
  endtask

  // One-dword memory write whose extra beats go to the flush path
  task automatic add_mwr(input int offset, input logic [31:0] value, input bit four_dw,
                         input int extra, input logic [2:0] effect, input logic [1:0] sel);
    packet_t     p;
    logic [31:0] addr;
    p = '0;
    addr = CTRL_BASE + 32'(offset * 4);
    p.hdr[0] = (four_dw ? 32'h6000_0000 : 32'h4000_0000) | 32'(1 + extra);
    p.hdr[1] = 32'h0000_00ff;
    p.hdr[2] = four_dw ? 32'd0 : addr;
    p.hdr[3] = addr;
    p.hdr_n  = four_dw ? 4 : 3;
    p.dat[0] = value;
    for (int i = 1; i <= extra; i++) begin
      p.dat[i] = ~value ^ 32'(i);
    end
    p.dat_n  = 1 + extra;
    p.effect = effect;
    p.idx    = offset;
    p.value  = value;
    p.sel    = sel;
    push_packet(p);
  endtask

  task automatic add_cpl(input int len, input logic [6:0] lower, input logic [31:0] base);
    packet_t p;
    p = '0;
    p.hdr[0] = 32'h4a00_0000 | 32'(len);
    // Completer ID and byte count
    p.hdr[1] = 32'h0100_0000 | 32'(len * 4);
    p.hdr[2] = {25'h0000010, lower};
    p.hdr_n  = 3;
    for (int i = 0; i < len; i++) begin
      p.dat[i] = base + 32'(i * 3);
    end
    p.dat_n  = len;
    p.effect = EFFECT_CPL;
    push_packet(p);
  endtask

  // Packets that must leave every output alone
  task automatic add_plain(input logic [31:0] hdr0, input int hdr_n, input int extra);
    packet_t p;
    p = '0;
    p.hdr[0] = hdr0;
    p.hdr[1] = 32'h0000_000f;
    p.hdr[2] = CTRL_BASE + 32'h40;
    p.hdr[3] = CTRL_BASE + 32'h44;
    p.hdr_n  = hdr_n;
    for (int i = 0; i < extra; i++) begin
      p.dat[i] = 32'h5555_0000 + 32'(i);
    end
    p.dat_n  = extra;
    p.effect = EFFECT_NONE;
    push_packet(p);
  endtask

  task automatic build_table();
    next_bar_hit = 7'd0;
    arm_req      = 1'b0;
    add_plain(32'h0000_0001, 3, 0);
    next_bar_hit = 7'd1;
    arm_req      = 1'b1;
    add_mwr(`REG_STATUS_ADDR, 32'h0000_1a2b, 0, 0, EFFECT_REG, ingress_pkg::SEL_CONTROL);
    add_mwr(`REG_WRITE_A_ADDR, 32'h1000_0040, 0, 0, EFFECT_REG, ingress_pkg::SEL_CONTROL);
    add_mwr(`REG_WRITE_B_ADDR, 32'h2000_0080, 1, 0, EFFECT_REG, ingress_pkg::SEL_CONTROL);
    add_mwr(`REG_READ_A_ADDR, 32'h3000_00c0, 0, 1, EFFECT_REG, ingress_pkg::SEL_CONTROL);
    add_mwr(`REG_READ_B_ADDR, 32'h4000_0100, 1, 0, EFFECT_REG, ingress_pkg::SEL_CONTROL);
    add_mwr(`REG_BUFFER_SIZE, 32'h0000_0800, 0, 0, EFFECT_REG, ingress_pkg::SEL_CONTROL);
    add_mwr(`REG_DEV_ADDR, 32'h0000_0055, 1, 2, EFFECT_REG, ingress_pkg::SEL_CONTROL);
    add_mwr(9, 32'hdead_beef, 0, 0, EFFECT_UNKNOWN, ingress_pkg::SEL_CONTROL);
    add_mwr(`CMD_PERIPH_WRITE, 32'd12, 0, 0, EFFECT_CMD, ingress_pkg::SEL_PERIPH);
    add_mwr(`CMD_PERIPH_READ, 32'd7, 1, 0, EFFECT_CMD, ingress_pkg::SEL_PERIPH);
    add_mwr(`CMD_MEM_WRITE, 32'd256, 0, 1, EFFECT_CMD, ingress_pkg::SEL_MEM);
    add_mwr(`CMD_MEM_READ, 32'd64, 0, 0, EFFECT_CMD, ingress_pkg::SEL_MEM);
    add_mwr(`CMD_PING, 32'hcafe_f00d, 0, 0, EFFECT_CMD, ingress_pkg::SEL_CONTROL);
    add_mwr(23, 32'h0000_0001, 0, 0, EFFECT_UNKNOWN, ingress_pkg::SEL_CONTROL);
    add_cpl(4, 7'h14, 32'ha000_0000);
    add_cpl(1, 7'h00, 32'ha100_0000);
    add_cpl(3, 7'h7c, 32'ha200_0000);
    // MRd 4DW, MRd with trailing beats, Msg, MsgD, Cpl without data
    add_plain(32'h2000_0004, 4, 0);
    add_plain(32'h0000_0001, 3, 2);
    add_plain(32'h3000_0000, 4, 0);
    add_plain(32'h7000_0002, 4, 2);
    add_plain(32'h0a00_0000, 3, 0);
    add_mwr(`CMD_RESET, 32'd3, 0, 0, EFFECT_CMD, ingress_pkg::SEL_CONTROL);
    arm_req = 1'b1;
    add_mwr(`REG_STATUS_ADDR, 32'h0000_5a5a, 0, 0, EFFECT_REG, ingress_pkg::SEL_CONTROL);
    add_mwr(`REG_WRITE_A_ADDR, 32'h1000_1000, 1, 0, EFFECT_REG, ingress_pkg::SEL_CONTROL);
    add_cpl(2, 7'h08, 32'hb000_0000);
  endtask

  // Runs from one falling edge to the first falling edge after acceptance
  task automatic send_beat(input logic [31:0] data, input logic last);
    int gap;
    gap = $urandom_range(3, 0);
    i_valid = 1'b0;
    repeat (gap) @(negedge clk);
    i_valid = 1'b1;
    i_data  = data;
    i_last  = last;
    while (!o_ready) @(negedge clk);
    @(negedge clk);
    i_valid = 1'b0;
  endtask

  task automatic update_model(input packet_t p);
    case (p.effect)
      EFFECT_REG: model_regs[p.idx] = p.value;
      EFFECT_CMD: begin
        model_cmd   = p.idx[4:0];
        model_sel   = p.sel;
        model_count = p.value;
        if (p.idx == `CMD_PING) begin
          model_ping = p.value;
        end
      end
      EFFECT_UNKNOWN: model_unknown = model_unknown + 8'd1;
      default: ;
    endcase
  endtask

  task automatic check_outputs(input packet_t p);
    logic [`BUF_AW-1:0] want_addr;
    int                 want_writes;
    check_value("o_status_addr", o_status_addr, model_regs[0]);
    check_value("o_write_a_addr", o_write_a_addr, model_regs[1]);
    check_value("o_write_b_addr", o_write_b_addr, model_regs[2]);
    check_value("o_read_a_addr", o_read_a_addr, model_regs[3]);
    check_value("o_read_b_addr", o_read_b_addr, model_regs[4]);
    check_value("o_buffer_size", o_buffer_size, model_regs[5]);
    check_value("o_dev_addr", o_dev_addr, model_regs[6]);
    check_value("o_ping_value", o_ping_value, model_ping);
    check_value("o_command", {27'd0, o_command}, {27'd0, model_cmd});
    check_value("o_device_select", {30'd0, o_device_select}, {30'd0, model_sel});
    check_value("o_cmd_data_count", o_cmd_data_count, model_count);
    check_value("o_unknown_count", {24'd0, o_unknown_count}, {24'd0, model_unknown});
    check_value("register strobes", 32'(reg_stb_seen), (p.effect == EFFECT_REG) ? 1 : 0);
    check_value("command strobes", 32'(cmd_stb_seen), (p.effect == EFFECT_CMD) ? 1 : 0);
    check_value("command resets", 32'(reset_seen),
                ((p.effect == EFFECT_CMD) && (p.idx == `CMD_RESET)) ? 1 : 0);
    check_value("config requests", 32'(req_seen), {31'd0, p.req});
    want_writes = (p.effect == EFFECT_CPL) ? p.dat_n : 0;
    check_value("buffer writes", 32'(buf_addr_q.size()), 32'(want_writes));
    for (int i = 0; i < want_writes; i++) begin
      // Offset plus lower address in dwords plus data index
      want_addr = BUF_OFFSET + 12'(p.hdr[2][6:2]) + 12'(i);
      check_value("o_buf_addr", {20'd0, buf_addr_q[i]}, {20'd0, want_addr});
      check_value("o_buf_data", buf_data_q[i], p.dat[i]);
    end
  endtask

  task automatic run_packet(input packet_t p);
    reg_stb_seen = 0;
    cmd_stb_seen = 0;
    reset_seen   = 0;
    req_seen     = 0;
    buf_addr_q.delete();
    buf_data_q.delete();
    i_bar_hit = p.bar_hit;
    for (int i = 0; i < p.hdr_n; i++) begin
      send_beat(p.hdr[i], (p.dat_n == 0) && (i == p.hdr_n - 1));
      if (i == 0) begin
        check_value("requests before first beat", 32'(req_seen), {31'd0, p.req});
      end
    end
    for (int i = 0; i < p.dat_n; i++) begin
      send_beat(p.dat[i], i == p.dat_n - 1);
    end
    // Let strobes and the command reset settle
    repeat (3) @(negedge clk);
    update_model(p);
    check_outputs(p);
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      assert (!(o_cfg_req && o_ready))
        else fail_run("o_ready went high while the config read was pending");
      if (o_reg_write_stb) reg_stb_seen++;
      if (o_cmd_stb) cmd_stb_seen++;
      if (o_cmd_reset) reset_seen++;
      if (o_cfg_req && !req_prev) req_seen++;
      if (o_buf_we) begin
        buf_addr_q.push_back(o_buf_addr);
        buf_data_q.push_back(o_buf_data);
      end
    end
    req_prev = o_cfg_req;
  end

  // Four-phase config reader with a short random latency
  initial begin
    i_cfg_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (o_cfg_req && !i_cfg_ack) begin
        repeat ($urandom_range(2, 0)) @(negedge clk);
        i_cfg_ack = 1'b1;
      end else if (!o_cfg_req && i_cfg_ack) begin
        i_cfg_ack = 1'b0;
      end
    end
  end

  initial begin
    wait (table_ready);
    repeat (CYCLES_PER_ENTRY * table_q.size()) @(posedge clk);
    $display("Timeout: the packet table did not finish in %0d cycles",
             CYCLES_PER_ENTRY * table_q.size());
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'h1148));
    rst                 = 1'b1;
    i_valid             = 1'b0;
    i_data              = 32'd0;
    i_last              = 1'b0;
    i_bar_hit           = 7'd0;
    i_control_addr_base = CTRL_BASE;
    i_buf_offset        = BUF_OFFSET;
    for (int i = 0; i < 7; i++) begin
      model_regs[i] = 32'd0;
    end
    model_ping    = 32'd0;
    model_cmd     = ingress_pkg::OP_RESET;
    model_sel     = ingress_pkg::SEL_CONTROL;
    model_count   = 32'd0;
    model_unknown = 8'd0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("o_ready after reset", {31'd0, o_ready}, 32'd0);
    check_value("o_cfg_req after reset", {31'd0, o_cfg_req}, 32'd0);
    check_value("o_reg_write_stb after reset", {31'd0, o_reg_write_stb}, 32'd0);
    check_value("o_cmd_stb after reset", {31'd0, o_cmd_stb}, 32'd0);
    check_value("o_buf_we after reset", {31'd0, o_buf_we}, 32'd0);
    check_value("o_device_select after reset", {30'd0, o_device_select}, 32'd0);
    foreach (table_q[n]) begin
      run_packet(table_q[n]);
    end
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/ingress_pkg.sv
source/ingress_fsm.sv
source/beat_counter.sv
source/tlp_header_decoder.sv
source/control_reg_file.sv
source/cpl_buffer_writer.sv
source/pcie_ingress_top.sv
bench/pcie_ingress_chk.sv
bench/pcie_ingress_tb.sv

// ==== Makefile ====
TOP       ?= pcie_ingress_tb
VERILATOR ?= verilator
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run into $(LOG), fail on a failed run"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: TOP VERILATOR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f list.f
	@./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
